// File: common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN 32

`define ARCH_REGS 16
`define ARCH_BITS 4
`define PHYS_REGS 32
`define PHYS_BITS 5

`define ROB_SIZE 16
`define SQN_BITS 5 // one wrap bit above the rob index.
`define IQ_SIZE 8
`define IMM_BITS 12

`define OP_ADD 3'd0
`define OP_SUB 3'd1
`define OP_AND 3'd2
`define OP_OR 3'd3
`define OP_XOR 3'd4
`define OP_SLL 3'd5 // shift amount from low 5 bits.
`define OP_SRL 3'd6
`define OP_SLT 3'd7 // signed compare.

`endif

// File: common/UOpPkg.sv
package UOpPkg;

`include "core_settings.svh"

// second operand word, register index or immediate per useImm.
typedef union packed {
    logic signed [`IMM_BITS-1:0] imm;
    logic [`IMM_BITS-1:0] regWord;
} Operand2_u;

function automatic logic [`ARCH_BITS-1:0] operandReg(Operand2_u opnd);
    return opnd.regWord[`ARCH_BITS-1:0];
endfunction

function automatic logic [`XLEN-1:0] operandImm(Operand2_u opnd);
    return {{(`XLEN-`IMM_BITS){opnd.imm[`IMM_BITS-1]}}, opnd.imm};
endfunction

function automatic logic [`XLEN-1:0] aluEval(
    input logic [2:0] op,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b
);
    logic [`XLEN-1:0] res;
    case (op)
        `OP_ADD: res = a + b;
        `OP_SUB: res = a - b;
        `OP_AND: res = a & b;
        `OP_OR: res = a | b;
        `OP_XOR: res = a ^ b;
        `OP_SLL: res = a << b[4:0];
        `OP_SRL: res = a >> b[4:0];
        default: res = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
    endcase
    return res;
endfunction

endpackage

// File: common/BackendPkg.sv
package BackendPkg;

`include "core_settings.svh"

// how far sqn lies behind refSqn.
// in-flight distances stay below half the sqn range, so the top bit
// marks an sqn that is actually ahead of refSqn.
function automatic logic [`SQN_BITS-1:0] sqnAge(
    input logic [`SQN_BITS-1:0] sqn,
    input logic [`SQN_BITS-1:0] refSqn
);
    return refSqn - sqn;
endfunction

endpackage

// File: rename/Rename.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module Rename import UOpPkg::*; (
    input wire clk,
    input wire rst,

    input logic inValid,
    input logic [`ARCH_BITS-1:0] inDst,
    input logic [`ARCH_BITS-1:0] inSrc1,
    input logic [2:0] inOp,
    input logic inUseImm,
    input Operand2_u inOperand2,
    output logic stall,

    input logic robFull,
    input logic iqFull,
    input logic freeValid,
    input logic [`PHYS_BITS-1:0] freeTag,
    input logic wbValid,
    input logic [`PHYS_BITS-1:0] wbTag,

    output logic rnValid,
    output logic [`SQN_BITS-1:0] rnSqn,
    output logic [`PHYS_BITS-1:0] rnDstTag,
    output logic [`PHYS_BITS-1:0] rnSrc1Tag,
    output logic rnSrc1Ready,
    output logic [`PHYS_BITS-1:0] rnSrc2Tag,
    output logic rnSrc2Ready,
    output logic [2:0] rnOp,
    output logic rnUseImm,
    output Operand2_u rnImm,
    output logic [`ARCH_BITS-1:0] rnDstArch,
    output logic [`PHYS_BITS-1:0] rnOldTag
);

localparam int FREE_SIZE = `PHYS_REGS - `ARCH_REGS;
localparam int FREE_BITS = $clog2(FREE_SIZE);
localparam logic [`PHYS_BITS-1:0] FIRST_FREE = `ARCH_REGS;

logic [`PHYS_BITS-1:0] mapTable[`ARCH_REGS];
logic [`PHYS_REGS-1:0] readyTable;
logic [`PHYS_BITS-1:0] freeList[FREE_SIZE];
logic [FREE_BITS-1:0] freeRd;
logic [FREE_BITS-1:0] freeWr;
logic [FREE_BITS:0] freeCount;
logic [`SQN_BITS-1:0] nextSqn;

logic accept;
logic [`PHYS_BITS-1:0] newTag;
logic [`PHYS_BITS-1:0] src1Tag;
logic [`PHYS_BITS-1:0] src2Tag;

assign stall = robFull || iqFull || (freeCount == '0);
assign accept = inValid && !stall;
assign newTag = freeList[freeRd];
assign src1Tag = mapTable[inSrc1];
assign src2Tag = mapTable[operandReg(inOperand2)];

always_ff @(posedge clk) begin
    if (rst) begin
        rnValid <= 1'b0;
        nextSqn <= '0;
        freeRd <= '0;
        freeWr <= '0;
        freeCount <= FREE_SIZE[FREE_BITS:0];
        readyTable <= '1; // initial tags all hold zero.
        for (int i = 0; i < `ARCH_REGS; i++)
            mapTable[i] <= i[`PHYS_BITS-1:0];
        for (int i = 0; i < FREE_SIZE; i++)
            freeList[i] <= FIRST_FREE + i[`PHYS_BITS-1:0];
    end else begin
        rnValid <= accept;
        if (wbValid)
            readyTable[wbTag] <= 1'b1;
        if (accept) begin
            nextSqn <= nextSqn + 1'b1;
            freeRd <= freeRd + 1'b1;
            mapTable[inDst] <= newTag;
            readyTable[newTag] <= 1'b0;
        end
        if (freeValid) begin
            freeList[freeWr] <= freeTag; // tag released at commit.
            freeWr <= freeWr + 1'b1;
        end
        freeCount <= freeCount + freeValid - accept;
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        rnSqn <= nextSqn;
        rnDstTag <= newTag;
        rnSrc1Tag <= src1Tag;
        rnSrc1Ready <= readyTable[src1Tag] || (wbValid && wbTag == src1Tag);
        rnSrc2Tag <= src2Tag;
        rnSrc2Ready <= inUseImm || readyTable[src2Tag] || (wbValid && wbTag == src2Tag);
        rnOp <= inOp;
        rnUseImm <= inUseImm;
        rnImm <= inOperand2;
        rnDstArch <= inDst;
        rnOldTag <= mapTable[inDst];
    end
end

endmodule

// File: issue/IssueQueue.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module IssueQueue import UOpPkg::*, BackendPkg::*; (
    input wire clk,
    input wire rst,

    input logic rnValid,
    input logic [`SQN_BITS-1:0] rnSqn,
    input logic [`PHYS_BITS-1:0] rnDstTag,
    input logic [`PHYS_BITS-1:0] rnSrc1Tag,
    input logic rnSrc1Ready,
    input logic [`PHYS_BITS-1:0] rnSrc2Tag,
    input logic rnSrc2Ready,
    input logic [2:0] rnOp,
    input logic rnUseImm,
    input Operand2_u rnImm,

    input logic wbValid,
    input logic [`PHYS_BITS-1:0] wbTag,
    output logic iqFull,

    output logic issValid,
    output logic [`SQN_BITS-1:0] issSqn,
    output logic [`PHYS_BITS-1:0] issDstTag,
    output logic [2:0] issOp,
    output logic [`PHYS_BITS-1:0] issSrc1Tag,
    output logic [`PHYS_BITS-1:0] issSrc2Tag,
    output logic issUseImm,
    output Operand2_u issImm
);

localparam int IQ_BITS = $clog2(`IQ_SIZE);

logic [`IQ_SIZE-1:0] entValid;
logic [`SQN_BITS-1:0] entSqn[`IQ_SIZE];
logic [`PHYS_BITS-1:0] entDst[`IQ_SIZE];
logic [`PHYS_BITS-1:0] entSrc1[`IQ_SIZE];
logic [`PHYS_BITS-1:0] entSrc2[`IQ_SIZE];
logic [`IQ_SIZE-1:0] entRdy1;
logic [`IQ_SIZE-1:0] entRdy2;
logic [2:0] entOp[`IQ_SIZE];
logic [`IQ_SIZE-1:0] entUseImm;
Operand2_u entImm[`IQ_SIZE];

logic [`IQ_SIZE-1:0] rdy1Now;
logic [`IQ_SIZE-1:0] rdy2Now;
logic [IQ_BITS-1:0] selIdx;
logic [IQ_BITS-1:0] freeIdx;

// the incoming uop is counted, issue frees are not.
assign iqFull = ($countones(entValid) + rnValid) >= `IQ_SIZE;

always_comb begin
    for (int i = 0; i < `IQ_SIZE; i++) begin
        rdy1Now[i] = entRdy1[i] || (wbValid && wbTag == entSrc1[i]);
        rdy2Now[i] = entRdy2[i] || (wbValid && wbTag == entSrc2[i]);
    end
end

always_comb begin
    logic [`SQN_BITS-1:0] age;
    issValid = 1'b0;
    selIdx = '0;
    for (int i = 0; i < `IQ_SIZE; i++) begin
        age = sqnAge(entSqn[i], entSqn[selIdx]);
        if (entValid[i] && rdy1Now[i] && rdy2Now[i] &&
                (!issValid || (age != '0 && !age[`SQN_BITS-1]))) begin
            issValid = 1'b1; // oldest ready so far.
            selIdx = i[IQ_BITS-1:0];
        end
    end
end

always_comb begin
    freeIdx = '0;
    for (int i = `IQ_SIZE - 1; i >= 0; i--)
        if (!entValid[i])
            freeIdx = i[IQ_BITS-1:0];
end

assign issSqn = entSqn[selIdx];
assign issDstTag = entDst[selIdx];
assign issOp = entOp[selIdx];
assign issSrc1Tag = entSrc1[selIdx];
assign issSrc2Tag = entSrc2[selIdx];
assign issUseImm = entUseImm[selIdx];
assign issImm = entImm[selIdx];

always_ff @(posedge clk) begin
    if (rst) begin
        entValid <= '0;
    end else begin
        if (issValid)
            entValid[selIdx] <= 1'b0;
        if (rnValid)
            entValid[freeIdx] <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    entRdy1 <= rdy1Now;
    entRdy2 <= rdy2Now;
    if (rnValid) begin
        entSqn[freeIdx] <= rnSqn;
        entDst[freeIdx] <= rnDstTag;
        entSrc1[freeIdx] <= rnSrc1Tag;
        entSrc2[freeIdx] <= rnSrc2Tag;
        entRdy1[freeIdx] <= rnSrc1Ready || (wbValid && wbTag == rnSrc1Tag);
        entRdy2[freeIdx] <= rnSrc2Ready || (wbValid && wbTag == rnSrc2Tag);
        entOp[freeIdx] <= rnOp;
        entUseImm[freeIdx] <= rnUseImm;
        entImm[freeIdx] <= rnImm;
    end
end

endmodule

// File: source/OperandFetch.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module OperandFetch import UOpPkg::*; (
    input wire clk,
    input wire rst,

    input logic issValid,
    input logic [`SQN_BITS-1:0] issSqn,
    input logic [`PHYS_BITS-1:0] issDstTag,
    input logic [2:0] issOp,
    input logic [`PHYS_BITS-1:0] issSrc1Tag,
    input logic [`PHYS_BITS-1:0] issSrc2Tag,
    input logic issUseImm,
    input Operand2_u issImm,

    input logic wbValid,
    input logic [`PHYS_BITS-1:0] wbTag,
    input logic [`XLEN-1:0] wbValue,

    output logic exValid,
    output logic [`SQN_BITS-1:0] exSqn,
    output logic [`PHYS_BITS-1:0] exDstTag,
    output logic [2:0] exOp,
    output logic [`XLEN-1:0] exSrcA,
    output logic [`XLEN-1:0] exSrcB
);

logic [`XLEN-1:0] regFile[`PHYS_REGS];
logic [`XLEN-1:0] readA;
logic [`XLEN-1:0] readB;

// bypass a write landing on the same edge.
assign readA = (wbValid && wbTag == issSrc1Tag) ? wbValue : regFile[issSrc1Tag];
assign readB = (wbValid && wbTag == issSrc2Tag) ? wbValue : regFile[issSrc2Tag];

always_ff @(posedge clk) begin
    if (rst) begin
        exValid <= 1'b0;
        for (int i = 0; i < `PHYS_REGS; i++)
            regFile[i] <= '0;
    end else begin
        exValid <= issValid;
        if (wbValid)
            regFile[wbTag] <= wbValue;
    end
end

always_ff @(posedge clk) begin
    exSqn <= issSqn;
    exDstTag <= issDstTag;
    exOp <= issOp;
    exSrcA <= readA;
    exSrcB <= issUseImm ? operandImm(issImm) : readB;
end

endmodule

// File: execute/IntAlu.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module IntAlu import UOpPkg::*; (
    input wire clk,
    input wire rst,

    input logic exValid,
    input logic [`SQN_BITS-1:0] exSqn,
    input logic [`PHYS_BITS-1:0] exDstTag,
    input logic [2:0] exOp,
    input logic [`XLEN-1:0] exSrcA,
    input logic [`XLEN-1:0] exSrcB,

    output logic wbValid,
    output logic [`PHYS_BITS-1:0] wbTag,
    output logic [`SQN_BITS-1:0] wbSqn,
    output logic [`XLEN-1:0] wbValue
);

logic s1Valid;
logic [`SQN_BITS-1:0] s1Sqn;
logic [`PHYS_BITS-1:0] s1Tag;
logic [`XLEN-1:0] s1Result;

always_ff @(posedge clk) begin
    if (rst) begin
        s1Valid <= 1'b0;
        wbValid <= 1'b0;
    end else begin
        s1Valid <= exValid;
        wbValid <= s1Valid;
    end
end

always_ff @(posedge clk) begin
    s1Sqn <= exSqn;
    s1Tag <= exDstTag;
    s1Result <= aluEval(exOp, exSrcA, exSrcB);
    wbSqn <= s1Sqn; // second stage drives the result bus.
    wbTag <= s1Tag;
    wbValue <= s1Result;
end

endmodule

// File: rob/ReorderBuffer.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module ReorderBuffer import BackendPkg::*; (
    input wire clk,
    input wire rst,

    input logic allocValid,
    input logic [`ARCH_BITS-1:0] allocDstArch,
    input logic [`PHYS_BITS-1:0] allocOldTag,

    input logic wbValid,
    input logic [`SQN_BITS-1:0] wbSqn,
    input logic [`XLEN-1:0] wbValue,

    output logic robFull,
    output logic freeValid,
    output logic [`PHYS_BITS-1:0] freeTag,

    output logic comValid,
    output logic [`ARCH_BITS-1:0] comReg,
    output logic [`XLEN-1:0] comValue
);

localparam int ROB_BITS = $clog2(`ROB_SIZE);

logic [`ARCH_BITS-1:0] robDst[`ROB_SIZE];
logic [`PHYS_BITS-1:0] robOld[`ROB_SIZE];
logic [`XLEN-1:0] robValue[`ROB_SIZE];
logic [`ROB_SIZE-1:0] robDone;
logic [`SQN_BITS-1:0] headSqn;
logic [`SQN_BITS-1:0] tailSqn;
logic [`SQN_BITS-1:0] occupancy;
logic [ROB_BITS-1:0] headIdx;
logic [ROB_BITS-1:0] tailIdx;
logic [ROB_BITS-1:0] wbIdx;

assign occupancy = sqnAge(headSqn, tailSqn);
assign headIdx = headSqn[ROB_BITS-1:0];
assign tailIdx = tailSqn[ROB_BITS-1:0];
assign wbIdx = wbSqn[ROB_BITS-1:0];

// one allocation may still be on its way from rename.
assign robFull = ({1'b0, occupancy} + allocValid) >= `ROB_SIZE;

assign comValid = (occupancy != '0) && robDone[headIdx];
assign comReg = robDst[headIdx];
assign comValue = robValue[headIdx];
assign freeValid = comValid; // old mapping is dead once committed.
assign freeTag = robOld[headIdx];

always_ff @(posedge clk) begin
    if (rst) begin
        headSqn <= '0;
        tailSqn <= '0;
        robDone <= '0;
    end else begin
        if (allocValid) begin
            tailSqn <= tailSqn + 1'b1;
            robDone[tailIdx] <= 1'b0;
        end
        if (wbValid)
            robDone[wbIdx] <= 1'b1;
        if (comValid)
            headSqn <= headSqn + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (allocValid) begin
        robDst[tailIdx] <= allocDstArch;
        robOld[tailIdx] <= allocOldTag;
    end
    if (wbValid)
        robValue[wbIdx] <= wbValue;
end

endmodule

// File: source/AluCore.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module AluCore import UOpPkg::*; (
    input wire clk,
    input wire rst,

    input logic inValid,
    input logic [`ARCH_BITS-1:0] inDst,
    input logic [`ARCH_BITS-1:0] inSrc1,
    input logic [2:0] inOp,
    input logic inUseImm,
    input Operand2_u inOperand2,
    output logic stall,

    output logic comValid,
    output logic [`ARCH_BITS-1:0] comReg,
    output logic [`XLEN-1:0] comValue
);

logic rnValid;
logic [`SQN_BITS-1:0] rnSqn;
logic [`PHYS_BITS-1:0] rnDstTag;
logic [`PHYS_BITS-1:0] rnSrc1Tag;
logic rnSrc1Ready;
logic [`PHYS_BITS-1:0] rnSrc2Tag;
logic rnSrc2Ready;
logic [2:0] rnOp;
logic rnUseImm;
Operand2_u rnImm;
logic [`ARCH_BITS-1:0] rnDstArch;
logic [`PHYS_BITS-1:0] rnOldTag;

logic issValid;
logic [`SQN_BITS-1:0] issSqn;
logic [`PHYS_BITS-1:0] issDstTag;
logic [2:0] issOp;
logic [`PHYS_BITS-1:0] issSrc1Tag;
logic [`PHYS_BITS-1:0] issSrc2Tag;
logic issUseImm;
Operand2_u issImm;

logic exValid;
logic [`SQN_BITS-1:0] exSqn;
logic [`PHYS_BITS-1:0] exDstTag;
logic [2:0] exOp;
logic [`XLEN-1:0] exSrcA;
logic [`XLEN-1:0] exSrcB;

logic wbValid;
logic [`PHYS_BITS-1:0] wbTag;
logic [`SQN_BITS-1:0] wbSqn;
logic [`XLEN-1:0] wbValue;

logic robFull;
logic iqFull;
logic freeValid;
logic [`PHYS_BITS-1:0] freeTag;

Rename rn (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inDst(inDst),
    .inSrc1(inSrc1),
    .inOp(inOp),
    .inUseImm(inUseImm),
    .inOperand2(inOperand2),
    .stall(stall),
    .robFull(robFull),
    .iqFull(iqFull),
    .freeValid(freeValid),
    .freeTag(freeTag),
    .wbValid(wbValid),
    .wbTag(wbTag),
    .rnValid(rnValid),
    .rnSqn(rnSqn),
    .rnDstTag(rnDstTag),
    .rnSrc1Tag(rnSrc1Tag),
    .rnSrc1Ready(rnSrc1Ready),
    .rnSrc2Tag(rnSrc2Tag),
    .rnSrc2Ready(rnSrc2Ready),
    .rnOp(rnOp),
    .rnUseImm(rnUseImm),
    .rnImm(rnImm),
    .rnDstArch(rnDstArch),
    .rnOldTag(rnOldTag)
);

IssueQueue iq (
    .clk(clk),
    .rst(rst),
    .rnValid(rnValid),
    .rnSqn(rnSqn),
    .rnDstTag(rnDstTag),
    .rnSrc1Tag(rnSrc1Tag),
    .rnSrc1Ready(rnSrc1Ready),
    .rnSrc2Tag(rnSrc2Tag),
    .rnSrc2Ready(rnSrc2Ready),
    .rnOp(rnOp),
    .rnUseImm(rnUseImm),
    .rnImm(rnImm),
    .wbValid(wbValid),
    .wbTag(wbTag),
    .iqFull(iqFull),
    .issValid(issValid),
    .issSqn(issSqn),
    .issDstTag(issDstTag),
    .issOp(issOp),
    .issSrc1Tag(issSrc1Tag),
    .issSrc2Tag(issSrc2Tag),
    .issUseImm(issUseImm),
    .issImm(issImm)
);

OperandFetch opFetch (
    .clk(clk),
    .rst(rst),
    .issValid(issValid),
    .issSqn(issSqn),
    .issDstTag(issDstTag),
    .issOp(issOp),
    .issSrc1Tag(issSrc1Tag),
    .issSrc2Tag(issSrc2Tag),
    .issUseImm(issUseImm),
    .issImm(issImm),
    .wbValid(wbValid),
    .wbTag(wbTag),
    .wbValue(wbValue),
    .exValid(exValid),
    .exSqn(exSqn),
    .exDstTag(exDstTag),
    .exOp(exOp),
    .exSrcA(exSrcA),
    .exSrcB(exSrcB)
);

IntAlu alu (
    .clk(clk),
    .rst(rst),
    .exValid(exValid),
    .exSqn(exSqn),
    .exDstTag(exDstTag),
    .exOp(exOp),
    .exSrcA(exSrcA),
    .exSrcB(exSrcB),
    .wbValid(wbValid),
    .wbTag(wbTag),
    .wbSqn(wbSqn),
    .wbValue(wbValue)
);

ReorderBuffer rob (
    .clk(clk),
    .rst(rst),
    .allocValid(rnValid),
    .allocDstArch(rnDstArch),
    .allocOldTag(rnOldTag),
    .wbValid(wbValid),
    .wbSqn(wbSqn),
    .wbValue(wbValue),
    .robFull(robFull),
    .freeValid(freeValid),
    .freeTag(freeTag),
    .comValid(comValid),
    .comReg(comReg),
    .comValue(comValue)
);

endmodule

// File: verif/AluCoreChecker.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module AluCoreChecker (
    input wire clk,
    input wire rst,
    input logic stall,
    input logic comValid,
    input logic [`ARCH_BITS-1:0] comReg,
    input logic [`XLEN-1:0] comValue,
    output logic done,
    output int errorCount
);

localparam int FIELDS = 8;
localparam int MAX_UOPS = 128;
localparam logic [31:0] END_MARK = 32'hff;
localparam int COMMIT_TIMEOUT = 400;
localparam int RESET_TIMEOUT = 50;
localparam int TAIL_CYCLES = 32;

logic [31:0] golden[MAX_UOPS*FIELDS];
int expTest[$];
logic [`ARCH_BITS-1:0] expReg[$];
logic [`XLEN-1:0] expValue[$];
int checkedCount;
int testErrors;
int stallCycles;

task automatic loadExpected();
    int n;
    n = 0;
    $readmemh("verif/alucore_golden.txt", golden);
    while (n < MAX_UOPS && golden[n*FIELDS] != END_MARK) begin
        expTest.push_back(int'(golden[n*FIELDS]));
        expReg.push_back(golden[n*FIELDS+6][`ARCH_BITS-1:0]);
        expValue.push_back(golden[n*FIELDS+7]);
        n++;
    end
endtask

// commit port quiet during reset, no stall right after it.
task automatic waitReset();
    int waited;
    waited = 0;
    while (rst !== 1'b0 && waited < RESET_TIMEOUT) begin
        @(posedge clk);
        waited++;
        if (rst === 1'b1 && comValid === 1'b1) begin
            $display("MISMATCH at %0t: comValid expected 0 got 1 during reset", $time);
            errorCount++;
        end
    end
    if (rst !== 1'b0) begin
        $display("ERROR: reset was never released");
        errorCount++;
    end else if (stall !== 1'b0) begin
        $display("MISMATCH at %0t: stall expected 0 got %b after reset", $time, stall);
        errorCount++;
    end
endtask

task automatic compareCommit(input int idx);
    if (comReg !== expReg[idx]) begin
        $display("MISMATCH at %0t: comReg expected %0h got %0h (commit %0d, test %0d)",
            $time, expReg[idx], comReg, idx, expTest[idx]);
        errorCount++;
        testErrors++;
    end
    if (comValue !== expValue[idx]) begin
        $display("MISMATCH at %0t: comValue expected %08h got %08h (commit %0d, test %0d)",
            $time, expValue[idx], comValue, idx, expTest[idx]);
        errorCount++;
        testErrors++;
    end
endtask

task automatic watchTail();
    repeat (TAIL_CYCLES) begin
        @(posedge clk);
        if (comValid === 1'b1) begin
            $display("ERROR at %0t: extra commit of r%0d beyond the expected sequence",
                $time, comReg);
            errorCount++;
        end
    end
endtask

// cycles where dispatch was held off.
always @(posedge clk) begin
    if (rst === 1'b0 && stall === 1'b1)
        stallCycles++;
end

initial begin
    int waited;
    int testCommits;
    bit lost;
    done = 1'b0;
    errorCount = 0;
    testErrors = 0;
    checkedCount = 0;
    stallCycles = 0;
    testCommits = 0;
    lost = 1'b0;
    loadExpected();
    waitReset();

    for (int i = 0; i < expTest.size() && !lost; i++) begin
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (comValid !== 1'b1 && waited < COMMIT_TIMEOUT);
        if (comValid !== 1'b1) begin
            $display("ERROR at %0t: commit %0d of test %0d never arrived",
                $time, i, expTest[i]);
            errorCount++;
            lost = 1'b1;
        end else begin
            compareCommit(i);
            checkedCount++;
            testCommits++;
            if (i == expTest.size() - 1 || expTest[i+1] != expTest[i]) begin
                $display("test %0d finished: %0d commits, %0d errors",
                    expTest[i], testCommits, testErrors);
                testCommits = 0;
                testErrors = 0;
            end
        end
    end

    if (!lost)
        watchTail();
    if (stallCycles == 0) begin
        $display("ERROR: stall never went high, back-pressure was not exercised");
        errorCount++;
    end
    $display("summary: %0d of %0d commits checked, %0d stall cycles, %0d errors",
        checkedCount, expTest.size(), stallCycles, errorCount);
    done = 1'b1;
end

endmodule

// File: verif/AluCoreTb.sv
`timescale 1ns/10ps

`include "core_settings.svh"

module AluCoreTb import UOpPkg::*; ();

localparam int FIELDS = 8; // words per golden line.
localparam int MAX_UOPS = 128;
localparam logic [31:0] END_MARK = 32'hff;
localparam logic [31:0] BURST_TEST = 32'd5;
localparam int STALL_TIMEOUT = 200;
localparam int DONE_TIMEOUT = 2000;

logic clk;
logic rst;
logic inValid;
logic [`ARCH_BITS-1:0] inDst;
logic [`ARCH_BITS-1:0] inSrc1;
logic [2:0] inOp;
logic inUseImm;
Operand2_u inOperand2;
logic stall;
logic comValid;
logic [`ARCH_BITS-1:0] comReg;
logic [`XLEN-1:0] comValue;

logic checkDone;
int checkErrors;
logic driveFailed;
integer seed;
logic [31:0] golden[MAX_UOPS*FIELDS];

AluCore i_AluCore (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inDst(inDst),
    .inSrc1(inSrc1),
    .inOp(inOp),
    .inUseImm(inUseImm),
    .inOperand2(inOperand2),
    .stall(stall),
    .comValid(comValid),
    .comReg(comReg),
    .comValue(comValue)
);

AluCoreChecker commitCheck (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .comValid(comValid),
    .comReg(comReg),
    .comValue(comValue),
    .done(checkDone),
    .errorCount(checkErrors)
);

always #20 clk = ~clk;

// holds the micro-op until the edge where stall is low.
task automatic sendUop(input int idx);
    int base;
    int waited;
    base = idx * FIELDS;
    waited = 0;
    inValid <= 1'b1;
    inDst <= golden[base+1][`ARCH_BITS-1:0];
    inSrc1 <= golden[base+2][`ARCH_BITS-1:0];
    inOp <= golden[base+3][2:0];
    inUseImm <= golden[base+4][0];
    inOperand2 <= golden[base+5][`IMM_BITS-1:0];
    do begin
        @(posedge clk);
        waited++;
    end while (stall && waited < STALL_TIMEOUT);
    if (stall) begin
        $display("ERROR at %0t: micro-op %0d never accepted, stall stayed high", $time, idx);
        driveFailed = 1'b1;
    end
endtask

// rare short gaps, so dispatch still outruns the dependency chain.
task automatic insertIdleGap();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] == 4'd0) begin
        inValid <= 1'b0;
        @(posedge clk); // single idle cycle.
    end
endtask

initial begin
    int n;
    int waited;
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    inDst = '0;
    inSrc1 = '0;
    inOp = '0;
    inUseImm = 1'b0;
    inOperand2 = '0;
    driveFailed = 1'b0;
    seed = 32'h9f54_8f58;
    $readmemh("verif/alucore_golden.txt", golden);

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    n = 0;
    while (n < MAX_UOPS && golden[n*FIELDS] != END_MARK && !driveFailed) begin
        sendUop(n);
        if (golden[n*FIELDS] == BURST_TEST)
            insertIdleGap();
        n++;
    end
    inValid <= 1'b0;

    waited = 0;
    while (checkDone !== 1'b1 && waited < DONE_TIMEOUT) begin
        @(posedge clk);
        waited++;
    end
    if (checkDone !== 1'b1)
        $display("ERROR: timed out waiting for the commit checker to finish");

    if (checkDone === 1'b1 && checkErrors == 0 && !driveFailed) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule

// File: verif/alucore_golden.txt
// hex words per line: test dst src1 op useImm operand2 expReg expValue
// op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt, test ff ends the list
1 1 2 0 1 000 1 00000000
1 3 4 0 0 005 3 00000000
2 1 0 0 1 123 1 00000123
2 2 1 1 1 023 2 00000100
2 3 1 2 1 0f0 3 00000020
2 4 1 3 1 700 4 00000723
2 5 1 4 1 fff 5 fffffedc
2 6 1 5 1 004 6 00001230
2 7 1 6 1 004 7 00000012
2 8 1 7 1 200 8 00000001
2 9 0 0 1 800 9 fffff800
2 a 9 7 1 001 a 00000001
2 b 9 6 1 01c b 0000000f
2 2 1 5 1 024 2 00001230
2 6 1 0 1 fff 6 00000122
2 7 9 1 1 ffe 7 fffff802
2 a 1 7 1 f00 a 00000000
3 3 1 0 0 004 3 00000846
3 4 3 1 0 006 4 00000724
3 5 4 4 0 002 5 00001514
3 6 5 5 0 008 6 00002a28
3 7 6 6 0 008 7 00001514
3 8 7 7 0 009 8 00000000
3 2 9 7 0 007 2 00000001
3 3 2 3 0 006 3 00002a29
3 4 3 2 0 006 4 00002a28
3 1 4 0 0 004 1 00005450
3 b 1 1 0 009 b 00005c50
4 5 0 0 1 011 5 00000011
4 6 5 0 1 001 6 00000012
4 5 5 0 0 006 5 00000023
4 7 5 5 1 002 7 0000008c
4 5 7 1 0 005 5 00000069
4 5 5 0 0 005 5 000000d2
4 8 5 3 0 006 8 000000d2
4 5 6 0 1 7ff 5 00000811
4 6 5 6 1 004 6 00000081
5 c c 0 1 001 c 00000001
5 d e 3 1 100 d 00000100
5 c c 0 1 001 c 00000002
5 d e 3 1 101 d 00000101
5 c c 0 1 001 c 00000003
5 d e 3 1 102 d 00000102
5 c c 0 1 001 c 00000004
5 d e 3 1 103 d 00000103
5 c c 0 1 001 c 00000005
5 d e 3 1 104 d 00000104
5 c c 0 1 001 c 00000006
5 d e 3 1 105 d 00000105
5 c c 0 1 001 c 00000007
5 d e 3 1 106 d 00000106
5 c c 0 1 001 c 00000008
5 d e 3 1 107 d 00000107
5 c c 0 1 001 c 00000009
5 d e 3 1 108 d 00000108
5 c c 0 1 001 c 0000000a
5 d e 3 1 109 d 00000109
5 c c 0 1 001 c 0000000b
5 d e 3 1 10a d 0000010a
5 c c 0 1 001 c 0000000c
5 d e 3 1 10b d 0000010b
5 c c 0 1 001 c 0000000d
5 d e 3 1 10c d 0000010c
5 c c 0 1 001 c 0000000e
5 d e 3 1 10d d 0000010d
5 c c 0 1 001 c 0000000f
5 d e 3 1 10e d 0000010e
5 c c 0 1 001 c 00000010
5 d e 3 1 10f d 0000010f
5 c c 0 1 001 c 00000011
5 d e 3 1 110 d 00000110
5 c c 0 1 001 c 00000012
5 d e 3 1 111 d 00000111
5 c c 0 1 001 c 00000013
5 d e 3 1 112 d 00000112
5 c c 0 1 001 c 00000014
5 d e 3 1 113 d 00000113
5 c c 0 1 001 c 00000015
5 d e 3 1 114 d 00000114
5 c c 0 1 001 c 00000016
5 d e 3 1 115 d 00000115
5 c c 0 1 001 c 00000017
5 d e 3 1 116 d 00000116
5 c c 0 1 001 c 00000018
5 d e 3 1 117 d 00000117
5 c c 0 1 001 c 00000019
5 d e 3 1 118 d 00000118
5 c c 0 1 001 c 0000001a
5 d e 3 1 119 d 00000119
5 c c 0 1 001 c 0000001b
5 d e 3 1 11a d 0000011a
5 c c 0 1 001 c 0000001c
5 d e 3 1 11b d 0000011b
5 c c 0 1 001 c 0000001d
5 d e 3 1 11c d 0000011c
5 c c 0 1 001 c 0000001e
5 d e 3 1 11d d 0000011d
ff 0 0 0 0 000 0 00000000

// File: verilog.f
+incdir+common
common/UOpPkg.sv
common/BackendPkg.sv
rename/Rename.sv
issue/IssueQueue.sv
source/OperandFetch.sv
execute/IntAlu.sv
rob/ReorderBuffer.sv
source/AluCore.sv
verif/AluCoreChecker.sv
verif/AluCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the AluCore testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=AluCoreSim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module AluCoreTb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG_FILE"; then
    exit 1
fi
exit 0
